// File: dv/decodeCases.txt
// instr dataWrite | readData1 readData2 imm1 imm2 toShift wordAlignJump | ctrl
// ctrl digits: aluOpr bSrc {invA invB slbi btr} setCtrl {br 0 cmd} {mem jmp pcadd immSrc} regSrc {we reg}
0000 0000  0000 0000 0000 0000 0000 0000  00000000
0140 BEEF  0000 0000 0000 0040 0040 0140  00000000
0380 BEEF  0000 0000 0000 FF80 0080 0380  00000000
05C0 BEEF  0000 0000 0000 FFC0 00C0 FDC0  00000000
0700 BEEF  0000 0000 0000 0000 0000 FF00  00000000
D94C 1234  0000 0000 000C 004C 004C 014C  4000002B
DB0C 5678  1234 0000 000C 000C 000C 030C  4000002B
DB71 A5A5  5678 5678 FFF1 0071 0071 0371  4080002C
DC16 00FF  A5A5 0000 FFF6 0016 0016 FC16  7000002D
DD9B 0F0F  00FF A5A5 FFFB FF9B 009B FD9B  5040002E
C280 FF80  0000 A5A5 0000 FF80 0080 0280  0200003A
D225 0101  FF80 0000 0005 0025 0025 0225  10000029
D162 0042  0101 5678 0002 0062 0062 0162  20000028
C808 4200  0042 0042 0008 0008 0008 0008  0010002A
4330 5668  5678 0101 FFF0 0030 0030 0330  41000029
4987 A99F  5668 A5A5 0007 FF87 0087 0187  4180002C
56BF 0F10  0F0F 00FF 001F 00BF 00BF FEBF  7100002D
5CD5 A98A  A99F 0F0F 0015 00D5 00D5 FCD5  5140002E
A563 7880  0F10 5678 0003 0063 0063 FD63  0100002B
A804 0420  0042 0042 0004 0004 0004 0004  11000028
B248 0042  4200 4200 0008 0048 0048 0248  2100002A
BE2F 5315  A98A 5668 000F 002F 002F FE2F  31000029
815E DEAD  5315 0042 FFFE 005E 005E 015E  41000800
8B82 1357  7880 A99F 0002 FF82 0082 0382  4100001C
90A5 20A5  0420 0F10 0005 00A5 00A5 00A5  60200028
9DC1 0F11  0F10 A98A 0001 FFC1 00C1 FDC1  4100082D
63F0 FFFF  7880 0000 FFF0 FFF0 00F0 03F0  40008100
6C10 1111  1357 20A5 FFF0 0010 0010 FC10  40009100
767F 2222  A98A 7880 FFFF 007F 007F FE7F  4040A100
7900 3333  5315 20A5 0000 0000 0000 0100  4040B100
27FF 4444  0000 0000 FFFF FFFF 00FF FFFF  40000200
3123 0102  5315 5315 0003 0023 0023 0123  4000020F
2F04 5555  0102 20A5 0004 0004 0004 FF04  42000400
3F88 0206  0102 1357 0008 FF88 0088 FF88  4200040F
E7AC 0000  0206 0F11 000C FFAC 00AC FFAC  0004002B
EB98 0001  0000 1357 FFF8 FF98 0098 0398  0005002E
F6E8 0000  0001 0206 0008 FFE8 00E8 FEE8  0007002A
FAD0 0001  0000 0001 FFF0 FFD0 00D0 02D0  0006002C
04E0 9999  0001 0206 0000 FFE0 00E0 FCE0  00000000

// File: dv/decodeTb.sv
module decodeTb import decodePkg::*; ();

   localparam int clkPeriod = 40;
   localparam int resetCycles = 5;
   localparam int fieldsPerCase = 9;                  // hex columns on one cases line
   localparam int maxCases = 64;
   localparam string casesPath = "dv/decodeCases.txt";

   logic       clk;
   logic       reset;
   word_t      instruction;
   word_t      dataWrite;

   word_t      readData1;
   word_t      readData2;
   word_t      imm1;
   word_t      imm2;
   word_t      toShift;
   word_t      wordAlignJump;
   aluOp_t     aluOpr;
   bSrc_t      bSrc;
   logic       invA;
   logic       invB;
   logic       slbi;
   logic       btr;
   setOp_t     setCtrl;
   logic       branching;
   branchCmd_t branchCmd;
   logic       memWrt;
   logic       aluJmp;
   logic       pcOrAdd;
   logic       immSrc;
   regSrc_t    regSrc;

   logic [31:0] caseMem [fieldsPerCase*maxCases];     // flat copy of the cases file
   word_t       refRegs [regCount];                   // expected register contents
   int          errorCount = 0;
   int          caseCount = 0;
   int          cycleCount = 0;
   int          cycleLimit = resetCycles + 20;        // raised once the cases are counted

   decode dut (
      .clk           (clk),
      .reset         (reset),
      .instruction   (instruction),
      .dataWrite     (dataWrite),
      .readData1     (readData1),
      .readData2     (readData2),
      .imm1          (imm1),
      .imm2          (imm2),
      .toShift       (toShift),
      .wordAlignJump (wordAlignJump),
      .aluOpr        (aluOpr),
      .bSrc          (bSrc),
      .invA          (invA),
      .invB          (invB),
      .slbi          (slbi),
      .btr           (btr),
      .setCtrl       (setCtrl),
      .branching     (branching),
      .branchCmd     (branchCmd),
      .memWrt        (memWrt),
      .aluJmp        (aluJmp),
      .pcOrAdd       (pcOrAdd),
      .immSrc        (immSrc),
      .regSrc        (regSrc)
   );

   initial clk = 1'b0;
   always #(clkPeriod/2) clk = ~clk;

   // watchdog on rising edges
   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("timeout: the run went past %0d cycles without finishing", cycleLimit);
         $display("errors: %0d, cases checked: %0d", errorCount, caseCount);
         $display("Verification failed");
         $finish;
      end
   end

   task automatic reportMismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
      errorCount++;
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
   endtask

   // compares one settled cycle against its cases line and the register model
   task automatic checkCase(input int n, input int base);
      logic [31:0] ctrl;                              // one hex digit per control field
      word_t       model1;
      word_t       model2;
      ctrl = caseMem[base+8];
      model1 = refRegs[instruction[10:8]];            // rs field
      model2 = refRegs[instruction[7:5]];             // rt field
      if (caseMem[base+2][15:0] !== model1 || caseMem[base+3][15:0] !== model2) begin
         errorCount++;
         $display("case %0d: read columns in the cases file disagree with the register model",
                  n);
      end
      if (readData1 !== caseMem[base+2][15:0])
         reportMismatch("readData1", caseMem[base+2][15:0], readData1);
      if (readData2 !== caseMem[base+3][15:0])
         reportMismatch("readData2", caseMem[base+3][15:0], readData2);
      if (imm1 !== caseMem[base+4][15:0]) reportMismatch("imm1", caseMem[base+4][15:0], imm1);
      if (imm2 !== caseMem[base+5][15:0]) reportMismatch("imm2", caseMem[base+5][15:0], imm2);
      if (toShift !== caseMem[base+6][15:0])
         reportMismatch("toShift", caseMem[base+6][15:0], toShift);
      if (wordAlignJump !== caseMem[base+7][15:0])
         reportMismatch("wordAlignJump", caseMem[base+7][15:0], wordAlignJump);
      if (aluOpr !== ctrl[30:28]) reportMismatch("aluOpr", 16'(ctrl[30:28]), 16'(aluOpr));
      if (bSrc !== ctrl[25:24]) reportMismatch("bSrc", 16'(ctrl[25:24]), 16'(bSrc));
      if (invA !== ctrl[23]) reportMismatch("invA", 16'(ctrl[23]), 16'(invA));
      if (invB !== ctrl[22]) reportMismatch("invB", 16'(ctrl[22]), 16'(invB));
      if (slbi !== ctrl[21]) reportMismatch("slbi", 16'(ctrl[21]), 16'(slbi));
      if (btr !== ctrl[20]) reportMismatch("btr", 16'(ctrl[20]), 16'(btr));
      if (setCtrl !== ctrl[18:16]) reportMismatch("setCtrl", 16'(ctrl[18:16]), 16'(setCtrl));
      if (branching !== ctrl[15]) reportMismatch("branching", 16'(ctrl[15]), 16'(branching));
      if (branchCmd !== ctrl[13:12])
         reportMismatch("branchCmd", 16'(ctrl[13:12]), 16'(branchCmd));
      if (memWrt !== ctrl[11]) reportMismatch("memWrt", 16'(ctrl[11]), 16'(memWrt));
      if (aluJmp !== ctrl[10]) reportMismatch("aluJmp", 16'(ctrl[10]), 16'(aluJmp));
      if (pcOrAdd !== ctrl[9]) reportMismatch("pcOrAdd", 16'(ctrl[9]), 16'(pcOrAdd));
      if (immSrc !== ctrl[8]) reportMismatch("immSrc", 16'(ctrl[8]), 16'(immSrc));
      if (regSrc !== ctrl[5:4]) reportMismatch("regSrc", 16'(ctrl[5:4]), 16'(regSrc));
      if (dut.writeEn !== ctrl[3]) reportMismatch("writeEn", 16'(ctrl[3]), 16'(dut.writeEn));
      if (ctrl[3] && dut.writeReg !== ctrl[2:0])    // destination only matters on a write
         reportMismatch("writeReg", 16'(ctrl[2:0]), 16'(dut.writeReg));
      if (ctrl[3]) refRegs[ctrl[2:0]] = dataWrite;   // lands at the coming rising edge
   endtask

   task automatic runCases();
      int base;
      $readmemh(casesPath, caseMem);
      caseCount = 0;
      while (caseCount < maxCases && caseMem[caseCount*fieldsPerCase][31:16] == 16'h0000) begin
         caseCount++;                                 // fill marker ends the list
      end
      if (caseCount == 0) begin
         errorCount++;
         $display("the cases file %s holds no cases", casesPath);
      end
      cycleLimit = caseCount + resetCycles + 20;
      $display("running %0d cases from %s", caseCount, casesPath);
      repeat (resetCycles) @(posedge clk);
      for (int n = 0; n < caseCount; n++) begin
         base = n * fieldsPerCase;
         @(negedge clk);
         reset = 1'b0;
         instruction = caseMem[base][15:0];
         dataWrite = caseMem[base+1][15:0];
         #(clkPeriod/4);                              // well before the next rising edge
         checkCase(n, base);
      end
      @(negedge clk);
   endtask

   initial begin
      int fd;
      reset = 1'b1;
      instruction = '0;                               // halt during reset
      dataWrite = '0;
      foreach (refRegs[r]) refRegs[r] = '0;
      for (int i = 0; i < fieldsPerCase*maxCases; i++) begin
         caseMem[i] = {16'hEEEE, 16'(i)};             // upper half marks unused words
      end
      fd = $fopen(casesPath, "r");
      if (fd == 0) begin
         $display("the cases file %s could not be opened", casesPath);
         $display("Verification failed");
         $finish;
      end else begin
         $fclose(fd);
         runCases();
         $display("errors: %0d, cases checked: %0d", errorCount, caseCount);
         if (errorCount == 0) begin
            $display("Verification passed");
         end else begin
            $display("Verification failed");
         end
         $finish;
      end
   end

endmodule

// File: rtl/controlDecoder.sv
module controlDecoder import decodePkg::*; (
   input  word_t      instruction,
   output logic       zeroExt,         // 1 zero extends the immediates
   output aluOp_t     aluOpr,
   output bSrc_t      bSrc,
   output logic       invA,            // complement operand a
   output logic       invB,            // complement operand b
   output logic       slbi,            // shift rs by 8 before the or
   output logic       btr,             // bit reverse of rs
   output logic       memWrt,
   output logic       aluJmp,          // pc from alu result
   output logic       pcOrAdd,         // pc from pc plus displacement
   output logic       immSrc,          // pc adder takes imm8 instead of displacement
   output regSrc_t    regSrc,
   output logic       branching,
   output branchCmd_t branchCmd,
   output setOp_t     setCtrl,
   output logic       writeEn,
   output regIdx_t    writeReg
);

   opcode_t opcode;                    // bits 15 to 11
   funct_t  funct;                     // bits 1 to 0
   regDst_t regDst;                    // which field names the destination

   assign opcode = instruction[15:11];
   assign funct = instruction[1:0];

   always_comb begin
      // everything idle unless a group turns it on
      zeroExt = 1'b0;
      aluOpr = aluRol;
      bSrc = bSrcReg;
      invA = 1'b0;
      invB = 1'b0;
      slbi = 1'b0;
      btr = 1'b0;
      memWrt = 1'b0;
      aluJmp = 1'b0;
      pcOrAdd = 1'b0;
      immSrc = 1'b0;
      regSrc = wbPc;
      branching = 1'b0;
      branchCmd = brEqz;
      setCtrl = setNone;
      writeEn = 1'b0;
      regDst = dstRt;

      case (opcode[4:2])
         grpJump: begin
            aluOpr = aluAdd;                     // rs plus imm for the register forms
            case (opcode[1:0])
               2'b00: begin                      // j
                  pcOrAdd = 1'b1;
               end
               2'b01: begin                      // jr
                  bSrc = bSrcImm8;
                  aluJmp = 1'b1;
               end
               2'b10: begin                      // jal
                  pcOrAdd = 1'b1;
                  regDst = dstLink;
                  writeEn = 1'b1;                // regSrc stays wbPc
               end
               default: begin                    // jalr
                  bSrc = bSrcImm8;
                  aluJmp = 1'b1;
                  regDst = dstLink;
                  writeEn = 1'b1;
               end
            endcase
         end

         grpImmArith: begin
            bSrc = bSrcImm5;
            regSrc = wbAlu;
            writeEn = 1'b1;                      // result goes to rt field
            case (opcode[1:0])
               2'b00: begin                      // addi
                  aluOpr = aluAdd;
               end
               2'b01: begin                      // subi computes imm minus rs
                  aluOpr = aluAdd;
                  invA = 1'b1;
               end
               2'b10: begin                      // xori
                  aluOpr = aluXor;
                  zeroExt = 1'b1;
               end
               default: begin                    // andni
                  aluOpr = aluAnd;
                  zeroExt = 1'b1;
                  invB = 1'b1;
               end
            endcase
         end

         grpBranch: begin
            aluOpr = aluAdd;
            branching = 1'b1;
            immSrc = 1'b1;                       // target is pc plus 2 plus imm8
            case (opcode[1:0])
               2'b00: branchCmd = brEqz;
               2'b01: branchCmd = brNez;
               2'b10: begin
                  branchCmd = brLtz;
                  invB = 1'b1;                   // sign test on rs
               end
               default: begin
                  branchCmd = brGez;
                  invB = 1'b1;
               end
            endcase
         end

         grpMem: begin
            aluOpr = aluAdd;                     // address is rs plus imm5
            bSrc = bSrcImm5;
            case (opcode[1:0])
               2'b00: begin                      // st stores the rt field
                  memWrt = 1'b1;
               end
               2'b01: begin                      // ld
                  regSrc = wbMem;
                  writeEn = 1'b1;
               end
               2'b10: begin                      // slbi
                  aluOpr = aluOr;
                  bSrc = bSrcReg;                // shifted rs is or'ed with toShift
                  slbi = 1'b1;
                  zeroExt = 1'b1;
                  regSrc = wbAlu;
                  regDst = dstRs;
                  writeEn = 1'b1;
               end
               default: begin                    // stu also writes the address back
                  memWrt = 1'b1;
                  regSrc = wbAlu;
                  regDst = dstRs;
                  writeEn = 1'b1;
               end
            endcase
         end

         grpImmShift: begin
            bSrc = bSrcImm5;                     // alu uses the low 4 bits only
            regSrc = wbAlu;
            writeEn = 1'b1;
            case (opcode[1:0])
               2'b00: aluOpr = aluRol;
               2'b01: aluOpr = aluSll;
               2'b10: aluOpr = aluRor;
               default: aluOpr = aluSrl;
            endcase
         end

         grpReg: begin
            writeEn = 1'b1;
            case (opcode[1:0])
               2'b00: begin                      // lbi loads signed imm8 into rs
                  bSrc = bSrcImm8;
                  regSrc = wbImm;
                  regDst = dstRs;
               end
               2'b01: begin                      // btr
                  btr = 1'b1;
                  regSrc = wbAlu;
                  regDst = dstRd;
               end
               2'b10: begin                      // register shifts by rt
                  regSrc = wbAlu;
                  regDst = dstRd;
                  case (funct)
                     2'b00: aluOpr = aluRol;
                     2'b01: aluOpr = aluSll;
                     2'b10: aluOpr = aluRor;
                     default: aluOpr = aluSrl;
                  endcase
               end
               default: begin                    // register arithmetic
                  regSrc = wbAlu;
                  regDst = dstRd;
                  case (funct)
                     2'b00: aluOpr = aluAdd;
                     2'b01: begin                // sub is rt minus rs
                        aluOpr = aluAdd;
                        invA = 1'b1;
                     end
                     2'b10: aluOpr = aluXor;
                     default: begin              // andn
                        aluOpr = aluAnd;
                        invB = 1'b1;
                     end
                  endcase
               end
            endcase
         end

         grpCompare: begin
            regSrc = wbAlu;
            regDst = dstRd;
            writeEn = 1'b1;
            case (opcode[1:0])
               2'b00: setCtrl = setEq;
               2'b01: setCtrl = setLt;
               2'b10: setCtrl = setCo;
               default: setCtrl = setLe;
            endcase
         end

         default: ;                              // halt keeps the idle controls
      endcase
   end

   // destination field select
   always_comb begin
      case (regDst)
         dstRt: writeReg = instruction[rtLsb +: regIdxWidth];
         dstRs: writeReg = instruction[rsLsb +: regIdxWidth];
         dstRd: writeReg = instruction[rdLsb +: regIdxWidth];
         default: writeReg = linkReg;
      endcase
   end

endmodule

// File: rtl/decode.sv
module decode import decodePkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  word_t      instruction,
   input  word_t      dataWrite,       // writeback value for this instruction
   output word_t      readData1,
   output word_t      readData2,
   output word_t      imm1,
   output word_t      imm2,
   output word_t      toShift,
   output word_t      wordAlignJump,
   output aluOp_t     aluOpr,
   output bSrc_t      bSrc,
   output logic       invA,
   output logic       invB,
   output logic       slbi,
   output logic       btr,
   output setOp_t     setCtrl,
   output logic       branching,
   output branchCmd_t branchCmd,
   output logic       memWrt,
   output logic       aluJmp,
   output logic       pcOrAdd,
   output logic       immSrc,
   output regSrc_t    regSrc
);

   logic    zeroExt;                   // decoder to extender
   logic    writeEn;                   // decoder to register file
   regIdx_t writeReg;

   controlDecoder ctrl (
      .instruction (instruction),
      .zeroExt     (zeroExt),
      .aluOpr      (aluOpr),
      .bSrc        (bSrc),
      .invA        (invA),
      .invB        (invB),
      .slbi        (slbi),
      .btr         (btr),
      .memWrt      (memWrt),
      .aluJmp      (aluJmp),
      .pcOrAdd     (pcOrAdd),
      .immSrc      (immSrc),
      .regSrc      (regSrc),
      .branching   (branching),
      .branchCmd   (branchCmd),
      .setCtrl     (setCtrl),
      .writeEn     (writeEn),
      .writeReg    (writeReg)
   );

   regFile regs (
      .clk       (clk),
      .reset     (reset),
      .readSel1  (instruction[rsLsb +: regIdxWidth]),   // rs
      .readSel2  (instruction[rtLsb +: regIdxWidth]),   // rt
      .writeSel  (writeReg),
      .writeData (dataWrite),
      .writeEn   (writeEn),
      .readData1 (readData1),
      .readData2 (readData2)
   );

   immExtend ext (
      .instruction   (instruction),
      .zeroExt       (zeroExt),
      .imm1          (imm1),
      .imm2          (imm2),
      .toShift       (toShift),
      .wordAlignJump (wordAlignJump)
   );

endmodule

// File: rtl/decodePkg.sv
package decodePkg;

   localparam int wordWidth = 16;                  // datapath word
   localparam int regCount = 8;                    // architectural registers
   localparam int regIdxWidth = $clog2(regCount);  // bits in a register index

   // instruction field positions
   localparam int rsLsb = 8;                       // rs sits in bits 10 to 8
   localparam int rtLsb = 5;                       // rt sits in bits 7 to 5
   localparam int rdLsb = 2;                       // rd sits in bits 4 to 2
   localparam int imm5Width = 5;                   // short immediate in bits 4 to 0
   localparam int imm8Width = 8;                   // long immediate in bits 7 to 0
   localparam int dispWidth = 11;                  // jump displacement in bits 10 to 0

   typedef logic [wordWidth-1:0] word_t;           // register data and immediates
   typedef logic [regIdxWidth-1:0] regIdx_t;       // register number
   typedef logic [4:0] opcode_t;                   // instruction bits 15 to 11
   typedef logic [1:0] funct_t;                    // instruction bits 1 to 0

   localparam regIdx_t linkReg = 3'd7;             // return address lands here

   // top three opcode bits pick the instruction group
   localparam logic [2:0] grpJump = 3'b001;
   localparam logic [2:0] grpImmArith = 3'b010;
   localparam logic [2:0] grpBranch = 3'b011;
   localparam logic [2:0] grpMem = 3'b100;
   localparam logic [2:0] grpImmShift = 3'b101;
   localparam logic [2:0] grpReg = 3'b110;
   localparam logic [2:0] grpCompare = 3'b111;     // 000 is halt and nop

   typedef enum logic [2:0] {
      aluRol = 3'd0,                               // rotate left
      aluSll = 3'd1,                               // shift left logical
      aluRor = 3'd2,                               // rotate right
      aluSrl = 3'd3,                               // shift right logical
      aluAdd = 3'd4,
      aluAnd = 3'd5,
      aluOr = 3'd6,
      aluXor = 3'd7
   } aluOp_t;

   typedef enum logic [1:0] {
      bSrcReg = 2'd0,                              // second read port
      bSrcImm5 = 2'd1,                             // extended bits 4 to 0
      bSrcImm8 = 2'd2                              // extended bits 7 to 0
   } bSrc_t;

   typedef enum logic [1:0] {
      wbPc = 2'd0,                                 // pc plus 2 for links
      wbMem = 2'd1,                                // load data
      wbAlu = 2'd2,
      wbImm = 2'd3                                 // immediate straight through
   } regSrc_t;

   typedef enum logic [1:0] {
      dstRt = 2'd0,
      dstRs = 2'd1,
      dstRd = 2'd2,
      dstLink = 2'd3
   } regDst_t;

   typedef enum logic [1:0] {
      brEqz = 2'd0,
      brNez = 2'd1,
      brLtz = 2'd2,
      brGez = 2'd3
   } branchCmd_t;

   typedef enum logic [2:0] {
      setNone = 3'd0,                              // plain alu result
      setEq = 3'd4,
      setLt = 3'd5,
      setLe = 3'd6,
      setCo = 3'd7                                 // carry out of rs plus rt
   } setOp_t;

endpackage

// File: rtl/immExtend.sv
module immExtend import decodePkg::*; (
   input  word_t instruction,
   input  logic  zeroExt,              // from the control decoder
   output word_t imm1,                 // bits 4 to 0 extended
   output word_t imm2,                 // bits 7 to 0 extended
   output word_t toShift,              // raw low byte for slbi
   output word_t wordAlignJump         // bits 10 to 0 sign extended
);

   logic imm1Fill;                     // upper bits of imm1
   logic imm2Fill;                     // upper bits of imm2

   assign imm1Fill = ~zeroExt & instruction[imm5Width-1];
   assign imm2Fill = ~zeroExt & instruction[imm8Width-1];

   assign imm1 = {{(wordWidth-imm5Width){imm1Fill}}, instruction[imm5Width-1:0]};
   assign imm2 = {{(wordWidth-imm8Width){imm2Fill}}, instruction[imm8Width-1:0]};

   assign toShift = {{(wordWidth-imm8Width){1'b0}}, instruction[imm8Width-1:0]};

   // displacement is always signed
   assign wordAlignJump = {{(wordWidth-dispWidth){instruction[dispWidth-1]}},
                           instruction[dispWidth-1:0]};

endmodule

// File: rtl/regFile.sv
module regFile import decodePkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  regIdx_t readSel1,           // rs
   input  regIdx_t readSel2,           // rt
   input  regIdx_t writeSel,
   input  word_t   writeData,
   input  logic    writeEn,
   output word_t   readData1,
   output word_t   readData2
);

   word_t regs [regCount];             // eight words of storage

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;             // every register starts at zero
         end
      end else if (writeEn) begin
         regs[writeSel] <= writeData;  // seen by reads from next cycle on
      end
   end

   // no write bypass so a same cycle read returns the old word
   assign readData1 = regs[readSel1];
   assign readData2 = regs[readSel2];

endmodule

// File: run.sh
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary -j 0 --top-module decodeTb -f src.f -o decodeSim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/decodeSim > sim.log 2>&1 \
   || echo "simulator returned a nonzero status"

cat sim.log

grep -qx "Verification passed" sim.log \
   && { echo "run.sh: test passed"; exit 0; } \
   || { echo "run.sh: test failed"; exit 1; }

// File: src.f
rtl/decodePkg.sv
rtl/controlDecoder.sv
rtl/regFile.sv
rtl/immExtend.sv
rtl/decode.sv
dv/decodeTb.sv
